// File: dds_pkg.sv
`default_nettype none

package dds_pkg;

  // chirp settings, held by the host for the whole sweep
  typedef struct packed {
    // start frequency, loaded on init
    logic [31:0] freq_offset;
    // frequency step added every active cycle
    logic [31:0] tuning_word_coeff;
    // sweep length in active cycles
    logic [31:0] count_max;
  } chirp_cfg_t;

  typedef struct packed {
    logic ready;
    logic active;
    logic done;
  } chirp_status_t;

  // one converter sample, I in the upper half
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq_sample_t;

endpackage

`default_nettype wire

// File: capture_pkg.sv
`default_nettype none

package capture_pkg;

  // lane source codes, as carried in the control word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_SAMPLE_CNT = 2'd2,
    ROUTE_GLBL_CNT   = 2'd3
  } route_t;

  typedef struct packed {
    logic [25:0] reserved_hi;
    route_t      route_upper;
    logic [1:0]  reserved_lo;
    route_t      route_lower;
  } ctrl_word_t;

  // one 32-bit lane, either a sample pair or a counter value
  typedef union packed {
    dds_pkg::iq_sample_t iq;
    logic [31:0]         count;
  } lane_word_u;

  typedef struct packed {
    // upper lane in 63:32, lower lane in 31:0
    logic [63:0] data;
    logic        first;
    logic        last;
  } capture_beat_t;

  typedef enum logic [1:0] {
    BEAT_HEADER  = 2'd0,
    BEAT_DATA    = 2'd1,
    BEAT_TRAILER = 2'd2
  } beat_kind_t;

endpackage

`default_nettype wire

// File: chirp_sawtooth_gen.sv
`timescale 1ns/100ps
`default_nettype none

module chirp_sawtooth_gen (
  input  wire logic                clk_245_76MHz,
  input  wire logic                cpu_reset,
  input  wire logic                chirp_init_i,
  input  wire logic                chirp_enable_i,
  input  wire dds_pkg::chirp_cfg_t cfg_i,
  output dds_pkg::chirp_status_t   status_o,
  output dds_pkg::iq_sample_t      sample_o
);
  import dds_pkg::*;

  logic [31:0] phase_r;
  logic [31:0] freq_r;
  logic [31:0] count_r;
  logic [31:0] count_nxt;
  logic        active_r;
  logic        done_r;

  assign count_nxt = count_r + 32'd1;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      phase_r  <= '0;
      freq_r   <= '0;
      count_r  <= '0;
      active_r <= 1'b0;
      done_r   <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done_r <= 1'b0;
      if (chirp_init_i) begin
        phase_r  <= '0;
        freq_r   <= cfg_i.freq_offset;
        count_r  <= '0;
        active_r <= 1'b1;
      end else if (active_r && chirp_enable_i) begin
        // linear chirp: phase ramps by freq, freq ramps by coeff
        phase_r <= phase_r + freq_r;
        freq_r  <= freq_r + cfg_i.tuning_word_coeff;
        count_r <= count_nxt;
        if (count_nxt == cfg_i.count_max) begin
          active_r <= 1'b0;
          done_r   <= 1'b1;
        end
      end
    end
  end

  assign status_o.ready  = ~active_r;
  assign status_o.active = active_r;
  assign status_o.done   = done_r;

  // sawtooth straight from the phase, Q a quarter turn ahead
  assign sample_o.i = phase_r[31:16];
  assign sample_o.q = phase_r[31:16] + 16'h4000;

endmodule

`default_nettype wire

// File: loopback_path.sv
`timescale 1ns/100ps
`default_nettype none

module loopback_path #(
  parameter int ADC_DELAY = 16
) (
  input  wire logic                clk_245_76MHz,
  input  wire logic                cpu_reset,
  input  wire dds_pkg::iq_sample_t dac_sample_i,
  output dds_pkg::iq_sample_t      dac_sample_rr_o,
  output dds_pkg::iq_sample_t      adc_sample_o
);
  import dds_pkg::*;

  // two register stages on the DAC side of the card
  iq_sample_t dac_r;
  iq_sample_t dac_rr;
  // adc return, one stage of halving plus ADC_DELAY stages of latency
  iq_sample_t adc_dly [ADC_DELAY+1];

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      dac_r  <= '0;
      dac_rr <= '0;
      for (int k = 0; k <= ADC_DELAY; k++) begin
        adc_dly[k] <= '0;
      end
    end else begin
      dac_r  <= dac_sample_i;
      dac_rr <= dac_r;
      // analog loss modelled as a 6 dB drop, sign kept
      adc_dly[0].i <= dac_rr.i >>> 1;
      adc_dly[0].q <= dac_rr.q >>> 1;
      for (int k = 1; k <= ADC_DELAY; k++) begin
        adc_dly[k] <= adc_dly[k-1];
      end
    end
  end

  assign dac_sample_rr_o = dac_rr;
  assign adc_sample_o    = adc_dly[ADC_DELAY];

endmodule

`default_nettype wire

// File: capture_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl #(
  parameter int FLUSH_CYCLES = 3,
  parameter int ALIGN_LOG2   = 3
) (
  input  wire logic          clk_245_76MHz,
  input  wire logic          cpu_reset,
  input  wire logic          adc_enable_i,
  input  wire logic          chirp_init_i,
  output logic               wr_en_o,
  output capture_pkg::beat_kind_t beat_kind_o
);
  import capture_pkg::*;

  localparam int FLUSH_W = (FLUSH_CYCLES > 0) ? $clog2(FLUSH_CYCLES + 1) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_PAD
  } ctrl_state_t;

  ctrl_state_t          state;
  logic                 en_r;
  logic [FLUSH_W-1:0]   flush_cnt;
  logic [ALIGN_LOG2-1:0] word_cnt;
  logic [ALIGN_LOG2-1:0] align_cnt;
  logic [ALIGN_LOG2-1:0] pad_cnt;
  logic                 window_live;

  // pads still owed before the trailer, so header..trailer fills whole bursts
  assign pad_cnt = ~word_cnt;

  // data keeps flowing while enabled or still flushing
  assign window_live = en_r || (flush_cnt != '0);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r      <= 1'b0;
      flush_cnt <= '0;
    end else begin
      en_r <= adc_enable_i;
      // (re)arm on enable falling edge or a new chirp
      if (chirp_init_i || (en_r && !adc_enable_i)) begin
        flush_cnt <= FLUSH_W'(FLUSH_CYCLES);
      end else if (flush_cnt != '0) begin
        flush_cnt <= flush_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state       <= ST_IDLE;
      wr_en_o     <= 1'b0;
      beat_kind_o <= BEAT_DATA;
      word_cnt    <= '0;
      align_cnt   <= '0;
    end else begin
      wr_en_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          // frame opens with the header
          if (en_r) begin
            wr_en_o     <= 1'b1;
            beat_kind_o <= BEAT_HEADER;
            word_cnt    <= ALIGN_LOG2'(1);
            state       <= ST_RUN;
          end
        end
        ST_RUN: begin
          wr_en_o  <= 1'b1;
          word_cnt <= word_cnt + 1'b1;
          if (window_live) begin
            beat_kind_o <= BEAT_DATA;
          end else if (pad_cnt == '0) begin
            // already aligned, close right away
            beat_kind_o <= BEAT_TRAILER;
            state       <= ST_IDLE;
          end else begin
            // first pad word goes out now
            beat_kind_o <= BEAT_DATA;
            align_cnt   <= pad_cnt - 1'b1;
            state       <= ST_PAD;
          end
        end
        ST_PAD: begin
          wr_en_o <= 1'b1;
          if (align_cnt == '0) begin
            beat_kind_o <= BEAT_TRAILER;
            state       <= ST_IDLE;
          end else begin
            beat_kind_o <= BEAT_DATA;
            align_cnt   <= align_cnt - 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: capture_word_builder.sv
`timescale 1ns/100ps
`default_nettype none

module capture_word_builder (
  input  wire logic                    clk_245_76MHz,
  input  wire logic                    cpu_reset,
  input  wire capture_pkg::ctrl_word_t ctrl_word_i,
  input  wire dds_pkg::iq_sample_t     adc_sample_i,
  input  wire dds_pkg::iq_sample_t     dac_sample_i,
  input  wire logic                    wr_en_i,
  input  wire capture_pkg::beat_kind_t beat_kind_i,
  output capture_pkg::capture_beat_t   beat_o,
  output logic                         beat_valid_o
);
  import dds_pkg::*;
  import capture_pkg::*;

  logic [31:0] glbl_cnt;
  logic [31:0] sample_cnt;
  route_t      route_lower_r;
  route_t      route_upper_r;
  lane_word_u  lane_lower;
  lane_word_u  lane_upper;

  // one lane mux, shared by both halves of the word
  function automatic lane_word_u pick_lane(input route_t route, input iq_sample_t adc,
                                           input iq_sample_t dac, input logic [31:0] s_cnt,
                                           input logic [31:0] g_cnt);
    lane_word_u w;
    case (route)
      ROUTE_ADC_IQ:     w.iq = adc;
      ROUTE_DAC_IQ:     w.iq = dac;
      ROUTE_SAMPLE_CNT: w.count = s_cnt;
      default:          w.count = g_cnt;
    endcase
    return w;
  endfunction

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt      <= '0;
      sample_cnt    <= '0;
      route_lower_r <= ROUTE_ADC_IQ;
      route_upper_r <= ROUTE_ADC_IQ;
      beat_valid_o  <= 1'b0;
    end else begin
      // free running timebase
      glbl_cnt <= glbl_cnt + 32'd1;
      // counts every word pushed toward the FIFO
      if (wr_en_i) begin
        sample_cnt <= sample_cnt + 32'd1;
      end
      route_lower_r <= ctrl_word_i.route_lower;
      route_upper_r <= ctrl_word_i.route_upper;
      beat_valid_o  <= wr_en_i;
    end
  end

  assign lane_lower = pick_lane(route_lower_r, adc_sample_i, dac_sample_i, sample_cnt, glbl_cnt);
  assign lane_upper = pick_lane(route_upper_r, adc_sample_i, dac_sample_i, sample_cnt, glbl_cnt);

  // payload stage
  always_ff @(posedge clk_245_76MHz) begin
    if (beat_kind_i == BEAT_DATA) begin
      beat_o.data <= {lane_upper, lane_lower};
    end else begin
      // header and trailer carry timestamps instead of samples
      beat_o.data <= {glbl_cnt, sample_cnt};
    end
    beat_o.first <= (beat_kind_i == BEAT_HEADER);
    beat_o.last  <= (beat_kind_i == BEAT_TRAILER);
  end

endmodule

`default_nettype wire

// File: capture_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module capture_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  wire logic                       clk_245_76MHz,
  input  wire logic                       cpu_reset,
  input  wire capture_pkg::capture_beat_t beat_i,
  input  wire logic                       beat_valid_i,
  output capture_pkg::capture_beat_t      m_beat_o,
  output logic                            m_valid_o,
  input  wire logic                       m_ready_i,
  output logic                            overflow_o
);
  import capture_pkg::*;

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

  capture_beat_t              mem [DEPTH];
  // extra msb tells full from empty
  logic [FIFO_DEPTH_LOG2:0]   wr_ptr;
  logic [FIFO_DEPTH_LOG2:0]   rd_ptr;
  logic                       empty;
  logic                       full;
  logic                       push;
  logic                       pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                 (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);
  // no back-pressure upstream, a push into a full FIFO is lost
  assign push  = beat_valid_i && !full;
  assign pop   = m_valid_o && m_ready_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= beat_i;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // sticky until reset
      if (beat_valid_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // head entry holds until popped
  assign m_valid_o = !empty;
  assign m_beat_o  = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

endmodule

`default_nettype wire

// File: chirp_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module chirp_capture_top #(
  parameter int ADC_DELAY       = 16,
  parameter int FLUSH_CYCLES    = 3,
  parameter int ALIGN_LOG2      = 3,
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  wire logic                    clk_245_76MHz,
  input  wire logic                    cpu_reset,
  input  wire logic                    chirp_init_i,
  input  wire logic                    chirp_enable_i,
  input  wire logic                    adc_enable_i,
  input  wire dds_pkg::chirp_cfg_t     chirp_cfg_i,
  input  wire capture_pkg::ctrl_word_t ctrl_word_i,
  output dds_pkg::chirp_status_t       chirp_status_o,
  output capture_pkg::capture_beat_t   m_beat_o,
  output logic                         m_valid_o,
  input  wire logic                    m_ready_i,
  output logic                         overflow_o
);
  import dds_pkg::*;
  import capture_pkg::*;

  iq_sample_t    dac_sample;
  iq_sample_t    dac_sample_rr;
  iq_sample_t    adc_sample;
  logic          wr_en;
  beat_kind_t    beat_kind;
  capture_beat_t beat;
  logic          beat_valid;

  chirp_sawtooth_gen u_chirp_sawtooth_gen (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .cfg_i          (chirp_cfg_i),
    .status_o       (chirp_status_o),
    .sample_o       (dac_sample)
  );

  // converter card stand-in
  loopback_path #(
    .ADC_DELAY (ADC_DELAY)
  ) u_loopback_path (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .dac_sample_i    (dac_sample),
    .dac_sample_rr_o (dac_sample_rr),
    .adc_sample_o    (adc_sample)
  );

  capture_ctrl #(
    .FLUSH_CYCLES (FLUSH_CYCLES),
    .ALIGN_LOG2   (ALIGN_LOG2)
  ) u_capture_ctrl (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .wr_en_o       (wr_en),
    .beat_kind_o   (beat_kind)
  );

  capture_word_builder u_capture_word_builder (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .ctrl_word_i   (ctrl_word_i),
    .adc_sample_i  (adc_sample),
    .dac_sample_i  (dac_sample_rr),
    .wr_en_i       (wr_en),
    .beat_kind_i   (beat_kind),
    .beat_o        (beat),
    .beat_valid_o  (beat_valid)
  );

  capture_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_capture_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .beat_i        (beat),
    .beat_valid_i  (beat_valid),
    .m_beat_o      (m_beat_o),
    .m_valid_o     (m_valid_o),
    .m_ready_i     (m_ready_i),
    .overflow_o    (overflow_o)
  );

endmodule

`default_nettype wire

// File: chirp_capture_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module chirp_capture_assertions (
  input wire logic                       clk_245_76MHz,
  input wire logic                       cpu_reset,
  input wire capture_pkg::capture_beat_t m_beat_o,
  input wire logic                       m_valid_o,
  input wire logic                       m_ready_i,
  input wire logic                       overflow_o,
  input wire dds_pkg::chirp_status_t     chirp_status_o
);

  // stalled beat must hold until taken
  property stall_holds_beat;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o));
  endproperty

  // overflow is sticky
  property overflow_sticky;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      overflow_o |=> overflow_o;
  endproperty

  property status_exclusive;
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      !(chirp_status_o.active && chirp_status_o.ready);
  endproperty

  a_stall_holds_beat: assert property (stall_holds_beat)
    else $error("output beat changed while stalled");
  a_overflow_sticky: assert property (overflow_sticky)
    else $error("overflow flag cleared without reset");
  a_status_exclusive: assert property (status_exclusive)
    else $error("chirp active and ready both high");

endmodule

bind chirp_capture_top chirp_capture_assertions u_chirp_capture_assertions (
  .clk_245_76MHz  (clk_245_76MHz),
  .cpu_reset      (cpu_reset),
  .m_beat_o       (m_beat_o),
  .m_valid_o      (m_valid_o),
  .m_ready_i      (m_ready_i),
  .overflow_o     (overflow_o),
  .chirp_status_o (chirp_status_o)
);

`default_nettype wire

// File: tb_chirp_capture.sv
`timescale 1ns/100ps
`default_nettype none

module tb_chirp_capture;
  import dds_pkg::*;
  import capture_pkg::*;

  localparam int ADC_DELAY       = 16;
  localparam int FLUSH_CYCLES    = 3;
  localparam int ALIGN_LOG2      = 3;
  localparam int FIFO_DEPTH_LOG2 = 5;
  localparam int FIELDS          = 8;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  logic          chirp_init_i;
  logic          chirp_enable_i;
  logic          adc_enable_i;
  chirp_cfg_t    chirp_cfg_i;
  ctrl_word_t    ctrl_word_i;
  chirp_status_t chirp_status_o;
  capture_beat_t m_beat_o;
  logic          m_valid_o;
  logic          m_ready_i;
  logic          overflow_o;

  logic [31:0]   stim_mem [0:127];
  logic [31:0]   lfsr_state;
  capture_beat_t frame_q [$];
  int            frames_seen;
  int            wd_cycles;
  // settings of the capture in progress
  logic [31:0]   cur_freq;
  logic [31:0]   cur_coeff;
  logic [1:0]    cur_rl;
  logic [1:0]    cur_ru;
  int            cur_window;
  int            bp_mode;

  chirp_capture_top #(
    .ADC_DELAY       (ADC_DELAY),
    .FLUSH_CYCLES    (FLUSH_CYCLES),
    .ALIGN_LOG2      (ALIGN_LOG2),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_chirp_capture_top (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .adc_enable_i   (adc_enable_i),
    .chirp_cfg_i    (chirp_cfg_i),
    .ctrl_word_i    (ctrl_word_i),
    .chirp_status_o (chirp_status_o),
    .m_beat_o       (m_beat_o),
    .m_valid_o      (m_valid_o),
    .m_ready_i      (m_ready_i),
    .overflow_o     (overflow_o)
  );

  always #10 clk_245_76MHz = ~clk_245_76MHz;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got));
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic take_lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'ha300_0000;
    end
    return b;
  endfunction

  function automatic logic [31:0] lane_of(input capture_beat_t b, input logic upper);
    return upper ? b.data[63:32] : b.data[31:0];
  endfunction

  // framing plus per-route data checks on one complete frame
  task automatic check_frame();
    int len;
    logic [31:0] prev;
    logic [31:0] cur;
    logic signed [15:0] up_i;
    logic signed [15:0] up_q;
    len = frame_q.size();
    assert (len % (2 ** ALIGN_LOG2) == 0) else show_mismatch("frame length mod 8", 0, len);
    assert (len >= cur_window + FLUSH_CYCLES) else abort_run("frame shorter than window plus flush");
    assert (frame_q[0].first) else abort_run("frame does not start with a header");
    assert (frame_q[len-1].last) else abort_run("frame does not end with a trailer");
    for (int p = 1; p < len - 1; p++) begin
      assert (!frame_q[p].first && !frame_q[p].last)
        else abort_run("first or last flag inside frame");
    end
    assert (frame_q[len-1].data[31:0] - frame_q[0].data[31:0] == len - 1)
      else show_mismatch("trailer sample count", frame_q[0].data[31:0] + len - 1,
                         frame_q[len-1].data[31:0]);
    for (int u = 0; u < 2; u++) begin
      for (int p = 1; p < len - 1; p++) begin
        cur = lane_of(frame_q[p], u[0]);
        prev = lane_of(frame_q[p-1], u[0]);
        // counter lanes step by one between data words
        if (((u ? cur_ru : cur_rl) >= 2'd2) && p >= 2) begin
          assert (cur == prev + 1) else show_mismatch("counter lane", prev + 1, cur);
        end
        if ((u ? cur_ru : cur_rl) == 2'd1) begin
          assert (cur[15:0] == cur[31:16] + 16'h4000)
            else show_mismatch("dac q", cur[31:16] + 16'h4000, cur[15:0]);
          if (p >= 2 && cur_coeff == 0 && cur_freq[15:0] == 16'h0) begin
            assert (cur[31:16] - prev[31:16] == cur_freq[31:16])
              else show_mismatch("dac i step", cur_freq[31:16], cur[31:16] - prev[31:16]);
          end
        end
      end
    end
    // adc lane is the dac lane halved ADC_DELAY+1 words later
    if (cur_rl == 2'd0 && cur_ru == 2'd1) begin
      for (int p = ADC_DELAY + 2; p < len - 1; p++) begin
        up_i = frame_q[p-ADC_DELAY-1].data[63:48];
        up_q = frame_q[p-ADC_DELAY-1].data[47:32];
        assert (frame_q[p].data[31:16] == 16'(up_i >>> 1))
          else show_mismatch("adc i", 16'(up_i >>> 1), frame_q[p].data[31:16]);
        assert (frame_q[p].data[15:0] == 16'(up_q >>> 1))
          else show_mismatch("adc q", 16'(up_q >>> 1), frame_q[p].data[15:0]);
      end
    end
  endtask

  // ready is decided first and a beat is taken when valid meets it
  always @(negedge clk_245_76MHz) begin : stream_sink
    logic bit_v;
    logic take;
    if (!cpu_reset) begin
      if (bp_mode == 0) begin
        m_ready_i = 1'b1;
      end else if (bp_mode == 1) begin
        bit_v = take_lfsr_bit();
        m_ready_i = !m_ready_i || bit_v;
      end else begin
        m_ready_i = 1'b0;
      end
      take = m_valid_o && m_ready_i;
      if (take) begin
        frame_q.push_back(m_beat_o);
        if (m_beat_o.last) begin
          check_frame();
          frame_q.delete();
          frames_seen++;
        end
      end
    end
  end

  task automatic check_chirp_status(input logic [31:0] cmax);
    int active_cycles;
    active_cycles = 0;
    while (chirp_status_o.active) begin
      active_cycles++;
      @(negedge clk_245_76MHz);
    end
    assert (active_cycles == cmax) else show_mismatch("chirp active cycles", cmax, active_cycles);
    assert (chirp_status_o.done && chirp_status_o.ready)
      else abort_run("no done pulse after the active phase");
    @(negedge clk_245_76MHz);
    assert (!chirp_status_o.done && chirp_status_o.ready)
      else abort_run("done pulse longer than one cycle");
  endtask

  task automatic run_window(input int exp_ovf);
    int start_frames;
    start_frames = frames_seen;
    repeat (4) @(negedge clk_245_76MHz);
    adc_enable_i = 1'b1;
    repeat (cur_window) @(negedge clk_245_76MHz);
    adc_enable_i = 1'b0;
    if (bp_mode == 2) begin
      repeat (FLUSH_CYCLES + 16) @(negedge clk_245_76MHz);
    end else begin
      wait (frames_seen == start_frames + 1);
    end
    assert (overflow_o == exp_ovf[0]) else show_mismatch("overflow_o", exp_ovf, overflow_o);
  endtask

  task automatic run_capture(input int k);
    int base;
    base = 1 + k * FIELDS;
    chirp_cfg_i.freq_offset       = stim_mem[base];
    chirp_cfg_i.tuning_word_coeff = stim_mem[base+1];
    chirp_cfg_i.count_max         = stim_mem[base+2];
    cur_freq   = stim_mem[base];
    cur_coeff  = stim_mem[base+1];
    cur_rl     = stim_mem[base+3][1:0];
    cur_ru     = stim_mem[base+4][1:0];
    cur_window = stim_mem[base+5];
    bp_mode    = stim_mem[base+6];
    ctrl_word_i             = '0;
    ctrl_word_i.route_lower = route_t'(cur_rl);
    ctrl_word_i.route_upper = route_t'(cur_ru);
    chirp_init_i = 1'b1;
    @(negedge clk_245_76MHz);
    chirp_init_i = 1'b0;
    fork
      check_chirp_status(stim_mem[base+2]);
      run_window(stim_mem[base+7]);
    join
    repeat (4) @(negedge clk_245_76MHz);
  endtask

  initial begin : main_seq
    int n_lines;
    int total;
    clk_245_76MHz  = 1'b0;
    cpu_reset      = 1'b1;
    chirp_init_i   = 1'b0;
    chirp_enable_i = 1'b1;
    adc_enable_i   = 1'b0;
    chirp_cfg_i    = '0;
    ctrl_word_i    = '0;
    m_ready_i      = 1'b0;
    lfsr_state     = 32'hb2fe_bd0d;
    frames_seen    = 0;
    wd_cycles      = 0;
    bp_mode        = 0;
    $readmemh("capture_stimulus.txt", stim_mem);
    n_lines = stim_mem[0];
    // watchdog budget from the window lengths
    total = 0;
    for (int k = 0; k < n_lines; k++) begin
      total += stim_mem[1 + k * FIELDS + 5] + 200;
    end
    wd_cycles = total;
    repeat (5) @(negedge clk_245_76MHz);
    cpu_reset = 1'b0;
    assert (!m_valid_o && !overflow_o) else abort_run("stream outputs not idle after reset");
    assert (chirp_status_o.ready && !chirp_status_o.active && !chirp_status_o.done)
      else abort_run("chirp status wrong after reset");
    for (int k = 0; k < n_lines; k++) begin
      run_capture(k);
    end
    $display("Test OK");
    $finish;
  end

  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk_245_76MHz);
    abort_run("watchdog expired before all captures finished");
  end

endmodule

`default_nettype wire

// File: capture_stimulus.txt
// first value is the number of capture lines
// columns: freq_offset coeff count_max route_lower route_upper window_cycles backpressure exp_overflow
// routes 0 adc, 1 dac, 2 sample count, 3 global count
// backpressure 0 always ready, 1 lfsr ready, 2 ready held low
00000006
// counter routes, sample count low, global count high
00010000 00000010 00000040 2 3 0000000e 0 0
// dac sawtooth on both lanes, constant frequency
01230000 00000000 00000050 1 1 00000014 0 0
// adc return low against dac high
00200000 00001000 00000060 0 1 0000001c 0 0
// counter routes swapped, lfsr back-pressure
00080000 00000020 00000030 3 2 00000018 1 0
// dac low, sample count high, lfsr back-pressure
00400000 00000000 00000050 1 2 00000010 1 0
// ready held low through a long window
00000000 00000000 00000020 2 3 00000040 2 1

// File: project.f
dds_pkg.sv
capture_pkg.sv
chirp_sawtooth_gen.sv
loopback_path.sv
capture_ctrl.sv
capture_word_builder.sv
capture_fifo.sv
chirp_capture_top.sv
chirp_capture_assertions.sv
tb_chirp_capture.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_chirp_capture
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
